// File: Makefile
# Verilator build and run for the mini_soc testbench

VERILATOR ?= verilator
TOP       ?= mini_soc_tb
FILELIST  ?= mini_soc.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation passed

SOURCES := $(wildcard rtl/*.sv rtl/*.svh verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "verdict: FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "verdict: FAIL (no pass line)"; exit 1; fi
	@echo "verdict: PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: mini_soc.f
+incdir+rtl
rtl/soc_bus_pkg.sv
rtl/soc_irq_pkg.sv
rtl/soc_bus_ctrl.sv
rtl/soc_gpio.sv
rtl/soc_timer.sv
rtl/soc_plic.sv
rtl/mini_soc.sv
verification/mini_soc_chk.sv
verification/mini_soc_tb.sv

// File: rtl/mini_soc.sv
// peripheral island top level
// bus controller, GPIO, timer and interrupt controller with irq routing

`timescale 1ns/100ps
`include "soc_defs.svh"

module mini_soc
  import soc_irq_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  // external bus
  input  logic                   i_req,
  input  logic                   i_we,
  input  logic [`SOC_ADDR_W-1:0] i_addr,
  input  logic [`SOC_DATA_W-1:0] i_wdata,
  output logic                   o_ack,
  output logic                   o_err,
  output logic [`SOC_DATA_W-1:0] o_rdata,
  // GPIO pins
  input  logic [`SOC_GPIO_W-1:0] i_gpio,
  output logic [`SOC_GPIO_W-1:0] o_gpio,
  output logic [`SOC_GPIO_W-1:0] o_gpio_dir,
  // combined interrupt
  output logic                   o_irq
);

  logic                      w_gpio_sel;
  logic                      w_tmr_sel;
  logic                      w_plic_sel;
  logic                      w_we;
  logic [`SOC_REG_IDX_W-1:0] w_reg_idx;
  logic [`SOC_DATA_W-1:0]    w_wdata;
  logic [`SOC_DATA_W-1:0]    w_gpio_rdata;
  logic [`SOC_DATA_W-1:0]    w_tmr_rdata;
  logic [`SOC_DATA_W-1:0]    w_plic_rdata;
  logic                      w_irq_gpio;
  logic                      w_irq_tmr;
  irq_vec_t                  w_irq_src;

  ////////////////////
  // interrupt routing, reserved and unused sources stay low
  assign w_irq_src = (irq_vec_t'(w_irq_gpio) << IRQ_GPIO)
                   | (irq_vec_t'(w_irq_tmr) << IRQ_TIMER);

  ////////////////////
  // decode and handshake
  soc_bus_ctrl u_bus_ctrl (
    .i_clk,
    .i_rst_n,
    .i_req,
    .i_we,
    .i_addr,
    .i_wdata,
    .o_ack,
    .o_err,
    .o_rdata,
    .o_gpio_sel   (w_gpio_sel),
    .o_tmr_sel    (w_tmr_sel),
    .o_plic_sel   (w_plic_sel),
    .o_we         (w_we),
    .o_reg_idx    (w_reg_idx),
    .o_wdata      (w_wdata),
    .i_gpio_rdata (w_gpio_rdata),
    .i_tmr_rdata  (w_tmr_rdata),
    .i_plic_rdata (w_plic_rdata)
  );

  // region 0
  soc_gpio u_gpio (
    .i_clk,
    .i_rst_n,
    .i_sel      (w_gpio_sel),
    .i_we       (w_we),
    .i_reg_idx  (w_reg_idx),
    .i_wdata    (w_wdata),
    .o_rdata    (w_gpio_rdata),
    .i_gpio,
    .o_gpio,
    .o_gpio_dir,
    .o_irq      (w_irq_gpio)
  );

  // region 1
  soc_timer u_timer (
    .i_clk,
    .i_rst_n,
    .i_sel     (w_tmr_sel),
    .i_we      (w_we),
    .i_reg_idx (w_reg_idx),
    .i_wdata   (w_wdata),
    .o_rdata   (w_tmr_rdata),
    .o_mtip    (w_irq_tmr)
  );

  // region 2
  soc_plic u_plic (
    .i_clk,
    .i_rst_n,
    .i_sel     (w_plic_sel),
    .i_we      (w_we),
    .i_reg_idx (w_reg_idx),
    .i_wdata   (w_wdata),
    .o_rdata   (w_plic_rdata),
    .i_irq_src (w_irq_src),
    .o_irq
  );

endmodule

// File: rtl/soc_bus_ctrl.sv
// bus controller of the peripheral island
// four-phase slave port, region decode, strobes and read data return

`timescale 1ns/100ps
`include "soc_defs.svh"

module soc_bus_ctrl
  import soc_bus_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  // external master
  input  logic                      i_req,
  input  logic                      i_we,
  input  logic [`SOC_ADDR_W-1:0]    i_addr,
  input  logic [`SOC_DATA_W-1:0]    i_wdata,
  output logic                      o_ack,
  output logic                      o_err,
  output logic [`SOC_DATA_W-1:0]    o_rdata,
  // peripheral strobes and shared write lines
  output logic                      o_gpio_sel,
  output logic                      o_tmr_sel,
  output logic                      o_plic_sel,
  output logic                      o_we,
  output logic [`SOC_REG_IDX_W-1:0] o_reg_idx,
  output logic [`SOC_DATA_W-1:0]    o_wdata,
  // combinational read words
  input  logic [`SOC_DATA_W-1:0]    i_gpio_rdata,
  input  logic [`SOC_DATA_W-1:0]    i_tmr_rdata,
  input  logic [`SOC_DATA_W-1:0]    i_plic_rdata
);

  // handshake states
  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_ACCESS = 2'd1;
  localparam logic [1:0] ST_WAIT   = 2'd2;

  logic [1:0]             state_q;
  // unmapped region seen at request time
  logic                   err_q;
  soc_addr_u              addr;
  logic                   hit_gpio;
  logic                   hit_tmr;
  logic                   hit_plic;
  logic [`SOC_DATA_W-1:0] rdata_mux;

  ////////////////////
  // region decode
  always_comb
  begin
    addr.flat = i_addr;
    hit_gpio  = (addr.fields.region == REGION_GPIO);
    hit_tmr   = (addr.fields.region == REGION_TIMER);
    hit_plic  = (addr.fields.region == REGION_PLIC);
  end

  // read return follows the strobe, zero when nothing was selected
  always_comb
  begin
    rdata_mux = '0;
    if (o_gpio_sel)
      rdata_mux = i_gpio_rdata;
    else if (o_tmr_sel)
      rdata_mux = i_tmr_rdata;
    else if (o_plic_sel)
      rdata_mux = i_plic_rdata;
  end

  ////////////////////
  // handshake FSM
  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
    begin
      state_q    <= ST_IDLE;
      err_q      <= 1'b0;
      o_gpio_sel <= 1'b0;
      o_tmr_sel  <= 1'b0;
      o_plic_sel <= 1'b0;
      o_ack      <= 1'b0;
      o_err      <= 1'b0;
      o_rdata    <= '0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          // one strobe at most, none for an unmapped region
          if (i_req)
          begin
            o_gpio_sel <= hit_gpio;
            o_tmr_sel  <= hit_tmr;
            o_plic_sel <= hit_plic;
            err_q      <= !(hit_gpio || hit_tmr || hit_plic);
            state_q    <= ST_ACCESS;
          end
        end
        ST_ACCESS:
        begin
          // peripheral writes on this edge, read word is captured
          o_gpio_sel <= 1'b0;
          o_tmr_sel  <= 1'b0;
          o_plic_sel <= 1'b0;
          o_ack      <= 1'b1;
          o_err      <= err_q;
          o_rdata    <= rdata_mux;
          state_q    <= ST_WAIT;
        end
        ST_WAIT:
        begin
          // hold ack and data until the master lets go
          if (!i_req)
          begin
            o_ack   <= 1'b0;
            o_err   <= 1'b0;
            state_q <= ST_IDLE;
          end
        end
        default:
          state_q <= ST_IDLE;
      endcase
    end
  end

  // write payload latched with the request, only used under a strobe
  always_ff @(posedge i_clk)
  begin
    if ((state_q == ST_IDLE) && i_req)
    begin
      o_we      <= i_we;
      o_reg_idx <= addr.fields.reg_idx;
      o_wdata   <= i_wdata;
    end
  end

endmodule

// File: rtl/soc_bus_pkg.sv
// bus address types
// address word with flat and field views, region names

`include "soc_defs.svh"

package soc_bus_pkg;

  ////////////////////
  // address word
  // flat view is what the master drives
  // field view is what the decoder looks at
  typedef union packed {
    logic [`SOC_ADDR_W-1:0] flat;
    struct packed {
      // selects the peripheral
      logic [`SOC_REGION_W-1:0] region;
      // word register inside the peripheral
      logic [`SOC_REG_IDX_W-1:0] reg_idx;
      // byte lane, accesses are word wide so it is ignored
      logic [1:0] byte_off;
    } fields;
  } soc_addr_u;

  ////////////////////
  // mapped regions, anything else is an error access
  typedef enum logic [`SOC_REGION_W-1:0] {
    REGION_GPIO  = `SOC_REGION_GPIO,
    REGION_TIMER = `SOC_REGION_TIMER,
    REGION_PLIC  = `SOC_REGION_PLIC
  } soc_region_e;

endpackage

// File: rtl/soc_defs.svh
// bus, GPIO and interrupt sizes for the peripheral island
// plus the address region codes used by the bus decoder

`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

////////////////////
// bus widths
`define SOC_ADDR_W 16
`define SOC_DATA_W 32

// address split, region on top, register index, byte offset at the bottom
`define SOC_REGION_W 4
`define SOC_REG_IDX_W 10

////////////////////
// peripheral sizes
`define SOC_GPIO_W 12
`define SOC_IRQ_N 8

////////////////////
// region codes, top nibble of the bus address
`define SOC_REGION_GPIO 4'd0
`define SOC_REGION_TIMER 4'd1
`define SOC_REGION_PLIC 4'd2

`endif

// File: rtl/soc_gpio.sv
// GPIO controller
// out/dir registers, pin synchronizer, masked rising-edge interrupt

`timescale 1ns/100ps
`include "soc_defs.svh"

module soc_gpio (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  // register access
  input  logic                      i_sel,
  input  logic                      i_we,
  input  logic [`SOC_REG_IDX_W-1:0] i_reg_idx,
  input  logic [`SOC_DATA_W-1:0]    i_wdata,
  output logic [`SOC_DATA_W-1:0]    o_rdata,
  // pins
  input  logic [`SOC_GPIO_W-1:0]    i_gpio,
  output logic [`SOC_GPIO_W-1:0]    o_gpio,
  output logic [`SOC_GPIO_W-1:0]    o_gpio_dir,
  output logic                      o_irq
);

  // register map
  localparam logic [`SOC_REG_IDX_W-1:0] REG_OUT  = 'd0;
  localparam logic [`SOC_REG_IDX_W-1:0] REG_DIR  = 'd1;
  localparam logic [`SOC_REG_IDX_W-1:0] REG_IN   = 'd2;
  localparam logic [`SOC_REG_IDX_W-1:0] REG_MASK = 'd3;
  localparam logic [`SOC_REG_IDX_W-1:0] REG_PEND = 'd4;

  logic [`SOC_GPIO_W-1:0] out_q;
  logic [`SOC_GPIO_W-1:0] dir_q;
  logic [`SOC_GPIO_W-1:0] mask_q;
  logic [`SOC_GPIO_W-1:0] pend_q;
  // two-flop synchronizer, in_q is the IN register
  logic [`SOC_GPIO_W-1:0] sync_q;
  logic [`SOC_GPIO_W-1:0] in_q;
  // previous IN value for edge detect
  logic [`SOC_GPIO_W-1:0] in_prev_q;
  logic                   wr;
  logic [`SOC_GPIO_W-1:0] rise;
  logic [`SOC_GPIO_W-1:0] pend_clr;

  assign wr       = i_sel && i_we;
  assign rise     = in_q & ~in_prev_q & mask_q;
  // write-one-to-clear on PEND
  assign pend_clr = (wr && (i_reg_idx == REG_PEND)) ? i_wdata[`SOC_GPIO_W-1:0] : '0;

  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
    begin
      out_q     <= '0;
      dir_q     <= '0;
      mask_q    <= '0;
      pend_q    <= '0;
      sync_q    <= '0;
      in_q      <= '0;
      in_prev_q <= '0;
    end
    else
    begin
      sync_q    <= i_gpio;
      in_q      <= sync_q;
      in_prev_q <= in_q;
      // a new edge wins over a clear in the same cycle
      pend_q    <= (pend_q & ~pend_clr) | rise;
      if (wr && (i_reg_idx == REG_OUT))
        out_q <= i_wdata[`SOC_GPIO_W-1:0];
      if (wr && (i_reg_idx == REG_DIR))
        dir_q <= i_wdata[`SOC_GPIO_W-1:0];
      if (wr && (i_reg_idx == REG_MASK))
        mask_q <= i_wdata[`SOC_GPIO_W-1:0];
    end
  end

  ////////////////////
  // read word, zero-extended, unknown index reads zero
  always_comb
  begin
    o_rdata = '0;
    case (i_reg_idx)
      REG_OUT:  o_rdata[`SOC_GPIO_W-1:0] = out_q;
      REG_DIR:  o_rdata[`SOC_GPIO_W-1:0] = dir_q;
      REG_IN:   o_rdata[`SOC_GPIO_W-1:0] = in_q;
      REG_MASK: o_rdata[`SOC_GPIO_W-1:0] = mask_q;
      REG_PEND: o_rdata[`SOC_GPIO_W-1:0] = pend_q;
      default:  o_rdata = '0;
    endcase
  end

  assign o_gpio     = out_q;
  assign o_gpio_dir = dir_q;
  assign o_irq      = |pend_q;

endmodule

// File: rtl/soc_irq_pkg.sv
// interrupt source numbering and source vector type

`include "soc_defs.svh"

package soc_irq_pkg;

  // source 0 is reserved and stays tied low
  // sources 3 to 7 have no peripheral behind them
  typedef enum logic [$clog2(`SOC_IRQ_N)-1:0] {
    IRQ_RESERVED = 0,
    IRQ_GPIO     = 1,
    IRQ_TIMER    = 2
  } irq_src_e;

  // one bit per source, bit index is the source number
  typedef logic [`SOC_IRQ_N-1:0] irq_vec_t;

endpackage

// File: rtl/soc_plic.sv
// platform interrupt controller
// pending/enable registers, lowest-number claim, single interrupt output

`timescale 1ns/100ps
`include "soc_defs.svh"

module soc_plic
  import soc_irq_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_sel,
  input  logic                      i_we,
  input  logic [`SOC_REG_IDX_W-1:0] i_reg_idx,
  input  logic [`SOC_DATA_W-1:0]    i_wdata,
  output logic [`SOC_DATA_W-1:0]    o_rdata,
  // level sources, bit index is the source number
  input  irq_vec_t                  i_irq_src,
  output logic                      o_irq
);

  localparam logic [`SOC_REG_IDX_W-1:0] REG_PENDING = 'd0;
  localparam logic [`SOC_REG_IDX_W-1:0] REG_ENABLE  = 'd1;
  localparam logic [`SOC_REG_IDX_W-1:0] REG_CLAIM   = 'd2;

  irq_vec_t               pend_q;
  irq_vec_t               en_q;
  irq_vec_t               pend_d;
  irq_vec_t               active;
  logic [`SOC_DATA_W-1:0] claim;

  // reserved source never pends
  always_comb
  begin
    pend_d               = i_irq_src;
    pend_d[IRQ_RESERVED] = 1'b0;
  end

  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
    begin
      pend_q <= '0;
      en_q   <= '0;
    end
    else
    begin
      // pending is a registered copy of the levels, software cannot clear it
      pend_q <= pend_d;
      if (i_sel && i_we && (i_reg_idx == REG_ENABLE))
        en_q <= i_wdata[`SOC_IRQ_N-1:0];
    end
  end

  assign active = pend_q & en_q;
  assign o_irq  = |active;

  ////////////////////
  // claim, lowest enabled pending source, 0 when idle
  // scan downward so the lowest index is written last
  always_comb
  begin
    claim = '0;
    for (int i = `SOC_IRQ_N - 1; i > 0; i--)
    begin
      if (active[i])
        claim = i;
    end
  end

  always_comb
  begin
    o_rdata = '0;
    case (i_reg_idx)
      REG_PENDING: o_rdata[`SOC_IRQ_N-1:0] = pend_q;
      REG_ENABLE:  o_rdata[`SOC_IRQ_N-1:0] = en_q;
      REG_CLAIM:   o_rdata = claim;
      default:     o_rdata = '0;
    endcase
  end

endmodule

// File: rtl/soc_timer.sv
// machine timer
// free-running counter, compare register, registered compare interrupt

`timescale 1ns/100ps
`include "soc_defs.svh"

module soc_timer (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_sel,
  input  logic                      i_we,
  input  logic [`SOC_REG_IDX_W-1:0] i_reg_idx,
  input  logic [`SOC_DATA_W-1:0]    i_wdata,
  output logic [`SOC_DATA_W-1:0]    o_rdata,
  output logic                      o_mtip
);

  localparam logic [`SOC_REG_IDX_W-1:0] REG_MTIME    = 'd0;
  localparam logic [`SOC_REG_IDX_W-1:0] REG_MTIMECMP = 'd1;
  localparam logic [`SOC_REG_IDX_W-1:0] REG_CTRL     = 'd2;

  logic [`SOC_DATA_W-1:0] mtime_q;
  logic [`SOC_DATA_W-1:0] cmp_q;
  // CTRL bit 0
  logic                   en_q;
  logic                   wr;

  assign wr = i_sel && i_we;

  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
    begin
      mtime_q <= '0;
      cmp_q   <= '0;
      en_q    <= 1'b0;
      o_mtip  <= 1'b0;
    end
    else
    begin
      // software write of MTIME beats the increment
      if (wr && (i_reg_idx == REG_MTIME))
        mtime_q <= i_wdata;
      else if (en_q)
        mtime_q <= mtime_q + 1'b1;
      if (wr && (i_reg_idx == REG_MTIMECMP))
        cmp_q <= i_wdata;
      if (wr && (i_reg_idx == REG_CTRL))
        en_q <= i_wdata[0];
      // compare lands one cycle after the counter
      o_mtip <= en_q && (mtime_q >= cmp_q);
    end
  end

  ////////////////////
  // read word
  always_comb
  begin
    case (i_reg_idx)
      REG_MTIME:    o_rdata = mtime_q;
      REG_MTIMECMP: o_rdata = cmp_q;
      REG_CTRL:     o_rdata = {{(`SOC_DATA_W-1){1'b0}}, en_q};
      default:      o_rdata = '0;
    endcase
  end

endmodule

// File: verification/mini_soc_chk.sv
// bus handshake assertions for the peripheral island
// bound onto the top level from the testbench

`timescale 1ns/100ps
`include "soc_defs.svh"

module mini_soc_chk (
  input logic                   i_clk,
  input logic                   i_rst_n,
  input logic                   i_req,
  input logic                   i_ack,
  input logic                   i_err,
  input logic [`SOC_DATA_W-1:0] i_rdata
);

  // failed assertions so far, read back at the end of the run
  int fail_cnt = 0;

  ////////////////////
  // handshake rules

  // ack only answers a live request
  ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $rose(i_ack) |-> i_req)
  else
  begin
    $error("o_ack rose while i_req was low");
    fail_cnt++;
  end

  // ack held for as long as the master holds the request
  ack_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_ack && i_req) |=> i_ack)
  else
  begin
    $error("o_ack dropped while i_req was still high");
    fail_cnt++;
  end

  // error is a flavour of acknowledge
  err_with_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_err |-> i_ack)
  else
  begin
    $error("o_err high without o_ack");
    fail_cnt++;
  end

  // read data frozen during the acknowledge
  rdata_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_ack |=> (!i_ack || $stable(i_rdata)))
  else
  begin
    $error("o_rdata changed while o_ack was high");
    fail_cnt++;
  end

endmodule

// File: verification/mini_soc_tb.sv
// testbench for the peripheral island
// bus tasks, shadow register model, access compare and cycle watchdog

`timescale 1ns/100ps
`include "soc_defs.svh"

module mini_soc_tb
  import soc_bus_pkg::*;
  import soc_irq_pkg::*;
();

  // roughly 45 accesses of ~6 cycles plus timer and pin waits, well under 1000
  localparam int MAX_CYCLES = 4000;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   req;
  logic                   we;
  logic [`SOC_ADDR_W-1:0] addr;
  logic [`SOC_DATA_W-1:0] wdata;
  logic                   ack;
  logic                   err;
  logic [`SOC_DATA_W-1:0] rdata;
  logic [`SOC_GPIO_W-1:0] gpio_in;
  logic [`SOC_GPIO_W-1:0] gpio_out;
  logic [`SOC_GPIO_W-1:0] gpio_dir;
  logic                   irq;
  int                     cyc = 0;
  int                     seed = 93;

  // shadow of what software wrote and what the pins did
  logic [`SOC_GPIO_W-1:0] sh_out;
  logic [`SOC_GPIO_W-1:0] sh_dir;
  logic [`SOC_GPIO_W-1:0] sh_mask;
  logic [`SOC_GPIO_W-1:0] sh_pend;
  logic [`SOC_GPIO_W-1:0] sh_pins;
  logic [`SOC_DATA_W-1:0] sh_cmp;
  logic                   sh_tmr_en;
  // timer has run past its compare value
  logic                   sh_tmr_fired;
  irq_vec_t               sh_plic_en;

  // expectation of the access in flight
  logic [`SOC_DATA_W-1:0] exp_data;
  logic                   exp_err;
  logic                   exp_read;
  // MTIME keeps counting, so only a lower bound is known
  logic                   exp_bound;
  logic                   ack_prev = 1'b0;

  always #20 clk = ~clk;

  mini_soc u_mini_soc (
    .i_clk      (clk),
    .i_rst_n    (rst_n),
    .i_req      (req),
    .i_we       (we),
    .i_addr     (addr),
    .i_wdata    (wdata),
    .o_ack      (ack),
    .o_err      (err),
    .o_rdata    (rdata),
    .i_gpio     (gpio_in),
    .o_gpio     (gpio_out),
    .o_gpio_dir (gpio_dir),
    .o_irq      (irq)
  );

  bind mini_soc mini_soc_chk u_chk (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_req   (i_req),
    .i_ack   (o_ack),
    .i_err   (o_err),
    .i_rdata (o_rdata)
  );

  ////////////////////
  // failure reporting
  task automatic end_in_failure();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic report_value(input string name, input logic [31:0] expv,
                              input logic [31:0] actv);
    $display("Error at %0t ns: %s expected 0x%h got 0x%h", $time, name, expv, actv);
    end_in_failure();
  endtask

  // cycle watchdog
  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES)
    begin
      $display("Timeout: test did not finish within %0d cycles", MAX_CYCLES);
      end_in_failure();
    end
  end

  ////////////////////
  // reference model
  function automatic logic [`SOC_ADDR_W-1:0] make_addr(input logic [3:0] region,
                                                       input int idx);
    soc_addr_u a;
    a.fields.region   = region;
    a.fields.reg_idx  = idx[`SOC_REG_IDX_W-1:0];
    a.fields.byte_off = 2'b00;
    return a.flat;
  endfunction

  // level sources as the interrupt controller should have registered them
  function automatic irq_vec_t plic_pending();
    irq_vec_t v;
    v            = '0;
    v[IRQ_GPIO]  = |sh_pend;
    v[IRQ_TIMER] = sh_tmr_fired;
    return v;
  endfunction

  function automatic logic ref_irq();
    return |(plic_pending() & sh_plic_en);
  endfunction

  // first enabled pending source counting up from 1
  function automatic int ref_claim();
    irq_vec_t act;
    int       n;
    act = plic_pending() & sh_plic_en;
    n   = 0;
    for (int i = 1; i < `SOC_IRQ_N; i++)
      if (act[i] && (n == 0))
        n = i;
    return n;
  endfunction

  // {error flag, read word}
  function automatic logic [`SOC_DATA_W:0] ref_read(input logic [`SOC_ADDR_W-1:0] a_flat);
    soc_addr_u              a;
    logic [`SOC_DATA_W-1:0] d;
    logic                   e;
    a.flat = a_flat;
    d      = '0;
    e      = 1'b0;
    case (a.fields.region)
      `SOC_REGION_GPIO:
        case (a.fields.reg_idx)
          0:       d[`SOC_GPIO_W-1:0] = sh_out;
          1:       d[`SOC_GPIO_W-1:0] = sh_dir;
          2:       d[`SOC_GPIO_W-1:0] = sh_pins;
          3:       d[`SOC_GPIO_W-1:0] = sh_mask;
          4:       d[`SOC_GPIO_W-1:0] = sh_pend;
          default: d = '0;
        endcase
      `SOC_REGION_TIMER:
        case (a.fields.reg_idx)
          0:       d = sh_cmp;
          1:       d = sh_cmp;
          2:       d[0] = sh_tmr_en;
          default: d = '0;
        endcase
      `SOC_REGION_PLIC:
        case (a.fields.reg_idx)
          0:       d[`SOC_IRQ_N-1:0] = plic_pending();
          1:       d[`SOC_IRQ_N-1:0] = sh_plic_en;
          2:       d = ref_claim();
          default: d = '0;
        endcase
      default:
        e = 1'b1;
    endcase
    return {e, d};
  endfunction

  task automatic shadow_write(input logic [`SOC_ADDR_W-1:0] a_flat,
                              input logic [`SOC_DATA_W-1:0] d);
    soc_addr_u a;
    a.flat = a_flat;
    case (a.fields.region)
      `SOC_REGION_GPIO:
        case (a.fields.reg_idx)
          0:       sh_out = d[`SOC_GPIO_W-1:0];
          1:       sh_dir = d[`SOC_GPIO_W-1:0];
          3:       sh_mask = d[`SOC_GPIO_W-1:0];
          4:       sh_pend = sh_pend & ~d[`SOC_GPIO_W-1:0];
          default: ;
        endcase
      `SOC_REGION_TIMER:
        case (a.fields.reg_idx)
          1:       sh_cmp = d;
          2:
          begin
            sh_tmr_en = d[0];
            if (!d[0])
              sh_tmr_fired = 1'b0;
          end
          default: ;
        endcase
      `SOC_REGION_PLIC:
        if (a.fields.reg_idx == 1)
          sh_plic_en = d[`SOC_IRQ_N-1:0];
      default: ;
    endcase
  endtask

  ////////////////////
  // compare every acknowledged access
  always @(negedge clk)
  begin
    if (ack && !ack_prev)
    begin
      assert (err === exp_err)
      else
      begin
        report_value("o_err", exp_err, err);
      end
      if (exp_read && exp_bound)
      begin
        assert (rdata >= exp_data)
        else
        begin
          report_value("o_rdata (lower bound)", exp_data, rdata);
        end
      end
      else if (exp_read || exp_err)
      begin
        assert (rdata === exp_data)
        else
        begin
          report_value("o_rdata", exp_data, rdata);
        end
      end
    end
    ack_prev = ack;
  end

  ////////////////////
  // bus master
  // hold is the number of extra cycles i_req stays up after the ack
  task automatic bus_access(input logic wr, input logic [`SOC_ADDR_W-1:0] a,
                            input logic [`SOC_DATA_W-1:0] d, input int hold);
    logic [`SOC_DATA_W:0] ref_word;
    soc_addr_u            au;
    int                   start;
    au.flat  = a;
    ref_word = ref_read(a);
    @(posedge clk);
    #2;
    exp_read  = !wr;
    exp_err   = ref_word[`SOC_DATA_W];
    exp_data  = ref_word[`SOC_DATA_W-1:0];
    exp_bound = (au.fields.region == `SOC_REGION_TIMER) && (au.fields.reg_idx == 0);
    we        = wr;
    addr      = a;
    wdata     = d;
    req       = 1'b1;
    start     = cyc;
    do
      @(negedge clk);
    while (!ack);
    // request sampled on the next edge, ack one edge later
    assert (cyc - start == 2)
    else
    begin
      report_value("o_ack latency", 2, cyc - start);
    end
    repeat (hold)
    begin
      @(negedge clk);
      assert (ack === 1'b1)
      else
      begin
        report_value("o_ack", 1, ack);
      end
    end
    @(posedge clk);
    #2;
    req = 1'b0;
    // first edge that sees the release drops ack
    @(posedge clk);
    @(negedge clk);
    assert (ack === 1'b0)
    else
    begin
      report_value("o_ack", 0, ack);
    end
  endtask

  task automatic bus_write(input logic [`SOC_ADDR_W-1:0] a, input logic [`SOC_DATA_W-1:0] d);
    bus_access(1'b1, a, d, 0);
    shadow_write(a, d);
  endtask

  task automatic bus_read(input logic [`SOC_ADDR_W-1:0] a);
    bus_access(1'b0, a, '0, 0);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // new pin levels, edges tracked against the mask in force
  task automatic drive_pins(input logic [`SOC_GPIO_W-1:0] v);
    @(posedge clk);
    #2;
    gpio_in = v;
    sh_pend = sh_pend | (v & ~sh_pins & sh_mask);
    sh_pins = v;
    // synchronizer, edge detect and interrupt controller register
    idle_cycles(6);
  endtask

  task automatic check_irq();
    assert (irq === ref_irq())
    else
    begin
      report_value("o_irq", ref_irq(), irq);
    end
  endtask

  ////////////////////
  // test sequence
  initial
  begin
    logic [`SOC_DATA_W-1:0] v;
    int                     pin_on;
    int                     pin_off;
    int                     wait_n;
    rst_n        = 1'b0;
    req          = 1'b0;
    we           = 1'b0;
    addr         = '0;
    wdata        = '0;
    gpio_in      = '0;
    sh_out       = '0;
    sh_dir       = '0;
    sh_mask      = '0;
    sh_pend      = '0;
    sh_pins      = '0;
    sh_cmp       = '0;
    sh_tmr_en    = 1'b0;
    sh_tmr_fired = 1'b0;
    sh_plic_en   = '0;
    exp_data     = '0;
    exp_err      = 1'b0;
    exp_read     = 1'b0;
    exp_bound    = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    assert (ack === 1'b0) else report_value("o_ack", 0, ack);
    assert (irq === 1'b0) else report_value("o_irq", 0, irq);
    assert (gpio_dir === '0) else report_value("o_gpio_dir", 0, gpio_dir);

    // handshake with the master holding the request
    bus_access(1'b0, make_addr(`SOC_REGION_GPIO, 0), '0, 4);

    // GPIO output path
    for (int k = 0; k < 8; k++)
    begin
      v = $random(seed);
      bus_write(make_addr(`SOC_REGION_GPIO, 0), v);
      v = $random(seed);
      bus_write(make_addr(`SOC_REGION_GPIO, 1), v);
      bus_read(make_addr(`SOC_REGION_GPIO, 0));
      bus_read(make_addr(`SOC_REGION_GPIO, 1));
      assert (gpio_out === sh_out) else report_value("o_gpio", sh_out, gpio_out);
      assert (gpio_dir === sh_dir) else report_value("o_gpio_dir", sh_dir, gpio_dir);
    end

    // GPIO inputs, one masked and one unmasked pin
    v       = $random(seed);
    pin_on  = v[3:0] % 6;
    pin_off = pin_on + 6;
    v       = $random(seed);
    v[pin_on]  = 1'b1;
    v[pin_off] = 1'b0;
    bus_write(make_addr(`SOC_REGION_GPIO, 3), {20'd0, v[`SOC_GPIO_W-1:0]});
    bus_write(make_addr(`SOC_REGION_PLIC, 1), 32'h1 << IRQ_GPIO);
    drive_pins(12'd1 << pin_off);
    bus_read(make_addr(`SOC_REGION_GPIO, 2));
    bus_read(make_addr(`SOC_REGION_GPIO, 4));
    check_irq();
    drive_pins(sh_pins | (12'd1 << pin_on));
    bus_read(make_addr(`SOC_REGION_GPIO, 2));
    bus_read(make_addr(`SOC_REGION_GPIO, 4));
    bus_read(make_addr(`SOC_REGION_PLIC, 0));
    check_irq();
    bus_write(make_addr(`SOC_REGION_GPIO, 4), {20'd0, sh_pend});
    idle_cycles(3);
    bus_read(make_addr(`SOC_REGION_GPIO, 4));
    bus_read(make_addr(`SOC_REGION_PLIC, 0));
    check_irq();

    // timer compare
    v      = $random(seed);
    wait_n = 20 + v[4:0];
    bus_write(make_addr(`SOC_REGION_TIMER, 1), wait_n);
    bus_write(make_addr(`SOC_REGION_TIMER, 2), 32'h1);
    idle_cycles(wait_n + 8);
    sh_tmr_fired = 1'b1;
    bus_read(make_addr(`SOC_REGION_PLIC, 0));
    bus_read(make_addr(`SOC_REGION_TIMER, 0));
    bus_read(make_addr(`SOC_REGION_TIMER, 2));
    bus_write(make_addr(`SOC_REGION_TIMER, 2), 32'h0);
    idle_cycles(3);
    bus_read(make_addr(`SOC_REGION_PLIC, 0));
    check_irq();

    // claim with both sources pending
    drive_pins(sh_pins & ~(12'd1 << pin_on));
    drive_pins(sh_pins | (12'd1 << pin_on));
    bus_write(make_addr(`SOC_REGION_TIMER, 2), 32'h1);
    idle_cycles(4);
    sh_tmr_fired = 1'b1;
    bus_write(make_addr(`SOC_REGION_PLIC, 1), (32'h1 << IRQ_GPIO) | (32'h1 << IRQ_TIMER));
    bus_read(make_addr(`SOC_REGION_PLIC, 2));
    check_irq();
    bus_write(make_addr(`SOC_REGION_PLIC, 1), 32'h1 << IRQ_TIMER);
    bus_read(make_addr(`SOC_REGION_PLIC, 2));
    bus_write(make_addr(`SOC_REGION_PLIC, 1), 32'h0);
    bus_read(make_addr(`SOC_REGION_PLIC, 2));
    check_irq();

    // unmapped region 3
    bus_read(make_addr(4'd3, 0));
    v = $random(seed);
    bus_write(make_addr(4'd3, 1), v);

    idle_cycles(2);
    if (u_mini_soc.u_chk.fail_cnt == 0)
    begin
      $display("Simulation passed");
      $finish;
    end
    else
    begin
      $display("Bus handshake checker reported %0d failures", u_mini_soc.u_chk.fail_cnt);
      end_in_failure();
    end
  end

endmodule
